// File: src/cpu_pkg.sv
/* CPU shared types and constants */
package cpu_pkg;

    // Meaningful widths
    typedef logic [63:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  alu_fs_t;
    typedef logic [1:0]  pc_fs_t;

    // Flags, bz is live from the ALU B operand
    typedef struct packed {
        logic v;
        logic c;
        logic n;
        logic z;
        logic bz;
    } status_t;

    typedef enum logic [1:0] {
        st_execute       = 2'b00,
        st_load_complete = 2'b01
    } state_t;

    // 33-bit control word, field order fixed
    typedef struct packed {
        logic      alu_enable;
        logic      alu_bs;
        alu_fs_t   alu_fs;
        logic      rf_b_enable;
        reg_addr_t register_sa;
        reg_addr_t register_sb;
        reg_addr_t register_wa;
        logic      register_w;
        logic      ram_enable;
        logic      ram_w;
        logic      pc_enable;
        pc_fs_t    pc_fs;
        logic      pc_input_select;
        logic      status_load;
        state_t    next_state;
    } ctrl_word_t;

    // ALU select in [4:2], invert B with carry in at [1], invert A at [0]
    localparam alu_fs_t alu_and = 5'b00000;
    localparam alu_fs_t alu_or  = 5'b00100;
    localparam alu_fs_t alu_add = 5'b01000;
    localparam alu_fs_t alu_sub = 5'b01010;
    localparam alu_fs_t alu_xor = 5'b01100;

    localparam pc_fs_t pc_hold = 2'b00;
    localparam pc_fs_t pc_inc  = 2'b01;
    localparam pc_fs_t pc_add  = 2'b10;
    localparam pc_fs_t pc_load = 2'b11;

    localparam reg_addr_t reg_zero = 5'd31;

    // Immediate class, bits 8 and 7 of instr[31:22] masked off
    localparam logic [9:0] op_imm_arith = 10'b1001000100;
    localparam logic [9:0] op_imm_mask  = 10'b1001111111;
    localparam int op_sub_bit  = 8;
    localparam int op_setf_bit = 7;

    // Register class, instr[31:22]
    localparam logic [9:0] op_add  = 10'b1000101100;
    localparam logic [9:0] op_adds = 10'b1010101100;
    localparam logic [9:0] op_sub  = 10'b1100101100;
    localparam logic [9:0] op_subs = 10'b1110101100;
    localparam logic [9:0] op_and  = 10'b1000101000;
    localparam logic [9:0] op_ands = 10'b1110101000;
    localparam logic [9:0] op_orr  = 10'b1010101000;
    localparam logic [9:0] op_eor  = 10'b1100101000;

    // Load and store, 9-bit unsigned byte offset in instr[20:12]
    localparam logic [9:0] op_ldur = 10'b1111100001;
    localparam logic [9:0] op_stur = 10'b1111100000;

    // Branches match the top 6 or 8 bits
    localparam logic [5:0] op_b     = 6'b000101;
    localparam logic [7:0] op_bcond = 8'b01010100;
    localparam logic [7:0] op_cbz   = 8'b10110100;
    localparam logic [7:0] op_cbnz  = 8'b10110101;

    localparam logic [3:0] cond_eq = 4'b0000;
    localparam logic [3:0] cond_ne = 4'b0001;
    localparam logic [3:0] cond_lt = 4'b1011;

endpackage

// File: src/imm_arith_decoder.sv
/* Immediate arithmetic decoder */
module imm_arith_decoder (
    input  cpu_pkg::instr_t     instr,
    output cpu_pkg::ctrl_word_t ctrl,
    output cpu_pkg::word_t      constant
);

    // Field split: opcode, imm12, Rn, Rd
    logic [9:0]         op;
    logic [11:0]        imm12;
    cpu_pkg::reg_addr_t rn;
    cpu_pkg::reg_addr_t rd;

    assign {op, imm12, rn, rd} = instr;

    // Zero-extended immediate
    assign constant = {52'd0, imm12};

    always_comb begin
        // ALU result onto the bus, B from the constant
        ctrl.alu_enable  = 1'b1;
        ctrl.alu_bs      = 1'b0;
        ctrl.alu_fs      = op[cpu_pkg::op_sub_bit] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
        ctrl.rf_b_enable = 1'b0;
        ctrl.register_sa = rn;
        ctrl.register_sb = '0;
        ctrl.register_wa = rd;
        ctrl.register_w  = 1'b1;
        // No memory traffic
        ctrl.ram_enable  = 1'b0;
        ctrl.ram_w       = 1'b0;
        // Step to the next instruction
        ctrl.pc_enable       = 1'b0;
        ctrl.pc_fs           = cpu_pkg::pc_inc;
        ctrl.pc_input_select = 1'b1;
        ctrl.status_load     = op[cpu_pkg::op_setf_bit];
        ctrl.next_state      = cpu_pkg::st_execute;
    end

endmodule

// File: src/register_file.sv
/* Register file */
module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t ra,
    input  cpu_pkg::reg_addr_t rb,
    input  cpu_pkg::reg_addr_t wa,
    input  logic               we,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rda,
    output cpu_pkg::word_t     rdb
);

    cpu_pkg::word_t regs [32];

    // Synchronous write, XZR never stored
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != cpu_pkg::reg_zero) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads
    // XZR forced to zero
    assign rda = (ra == cpu_pkg::reg_zero) ? '0 : regs[ra];
    assign rdb = (rb == cpu_pkg::reg_zero) ? '0 : regs[rb];

endmodule

// File: src/alu.sv
/* 64-bit ALU */
module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_fs_t fs,
    output cpu_pkg::word_t   y,
    output cpu_pkg::status_t flags
);

    cpu_pkg::word_t a_in;
    cpu_pkg::word_t b_in;
    cpu_pkg::word_t sum;
    logic           carry;
    logic           arith;

    // Operand inversion, B inversion also feeds carry in
    assign a_in = fs[0] ? ~a : a;
    assign b_in = fs[1] ? ~b : b;

    assign {carry, sum} = {1'b0, a_in} + {1'b0, b_in} + {64'd0, fs[1]};
    assign arith        = fs[4:2] == 3'b010;

    always_comb begin
        case (fs[4:2])
            3'b000:  y = a_in & b_in;
            3'b001:  y = a_in | b_in;
            3'b010:  y = sum;
            3'b011:  y = a_in ^ b_in;
            // Shift codes unused
            default: y = '0;
        endcase
    end

    // C and V only meaningful on add or subtract
    assign flags.v  = arith && (a_in[63] == b_in[63]) && (sum[63] != a_in[63]);
    assign flags.c  = arith && carry;
    assign flags.n  = y[63];
    assign flags.z  = y == '0;
    // For CBZ and CBNZ
    assign flags.bz = b == '0;

endmodule

// File: src/control_unit.sv
/* Control unit */
module control_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::instr_t     instr,
    input  cpu_pkg::status_t    status,
    output cpu_pkg::ctrl_word_t ctrl,
    output cpu_pkg::word_t      constant
);

    cpu_pkg::state_t     state_q;
    cpu_pkg::ctrl_word_t ctrl_imm;
    cpu_pkg::ctrl_word_t ctrl_dec;
    cpu_pkg::word_t      const_imm;
    cpu_pkg::word_t      const_dec;
    logic [9:0]          op;
    logic                imm_class;
    logic                cond_base;
    logic                cond_taken;

    assign op        = instr[31:22];
    assign imm_class = (op & cpu_pkg::op_imm_mask) == cpu_pkg::op_imm_arith;

    imm_arith_decoder u_imm (
        .instr    (instr),
        .ctrl     (ctrl_imm),
        .constant (const_imm)
    );

    // B.cond evaluation, low bit inverts except for always
    always_comb begin
        case (instr[3:1])
            3'b000:  cond_base = status.z;
            3'b001:  cond_base = status.c;
            3'b010:  cond_base = status.n;
            3'b011:  cond_base = status.v;
            3'b100:  cond_base = status.c && !status.z;
            3'b101:  cond_base = status.n == status.v;
            3'b110:  cond_base = (status.n == status.v) && !status.z;
            default: cond_base = 1'b1;
        endcase
        cond_taken = (instr[0] && instr[3:1] != 3'b111) ? !cond_base : cond_base;
    end

    always_comb begin
        // Default is a bus-idle step, PC on the bus
        ctrl_dec                 = '0;
        ctrl_dec.pc_enable       = 1'b1;
        ctrl_dec.pc_fs           = cpu_pkg::pc_inc;
        ctrl_dec.pc_input_select = 1'b1;
        ctrl_dec.next_state      = cpu_pkg::st_execute;
        const_dec                = '0;
        if (op == cpu_pkg::op_ldur || op == cpu_pkg::op_stur) begin
            // Address is Rn plus the byte offset
            const_dec            = {55'd0, instr[20:12]};
            ctrl_dec.alu_fs      = cpu_pkg::alu_add;
            ctrl_dec.register_sa = instr[9:5];
            ctrl_dec.register_sb = instr[4:0];
            ctrl_dec.pc_enable   = 1'b0;
            if (op == cpu_pkg::op_stur) begin
                // Rt rides the bus into the RAM
                ctrl_dec.rf_b_enable = 1'b1;
                ctrl_dec.ram_w       = 1'b1;
            end else if (state_q == cpu_pkg::st_execute) begin
                // RAM latches the address, PC waits
                ctrl_dec.alu_enable = 1'b1;
                ctrl_dec.pc_fs      = cpu_pkg::pc_hold;
                ctrl_dec.next_state = cpu_pkg::st_load_complete;
            end else begin
                ctrl_dec.ram_enable  = 1'b1;
                ctrl_dec.register_wa = instr[4:0];
                ctrl_dec.register_w  = 1'b1;
            end
        end else if (op[9:4] == cpu_pkg::op_b) begin
            const_dec      = {{36{instr[25]}}, instr[25:0], 2'b00};
            ctrl_dec.pc_fs = cpu_pkg::pc_add;
        end else if (op[9:2] == cpu_pkg::op_bcond) begin
            const_dec      = {{43{instr[23]}}, instr[23:5], 2'b00};
            ctrl_dec.pc_fs = cond_taken ? cpu_pkg::pc_add : cpu_pkg::pc_inc;
        end else if (op[9:2] == cpu_pkg::op_cbz || op[9:2] == cpu_pkg::op_cbnz) begin
            // Rt on the ALU B operand gives the live bz flag
            const_dec            = {{43{instr[23]}}, instr[23:5], 2'b00};
            ctrl_dec.alu_bs      = 1'b1;
            ctrl_dec.register_sb = instr[4:0];
            ctrl_dec.pc_fs       = (status.bz != op[2]) ? cpu_pkg::pc_add : cpu_pkg::pc_inc;
        end else begin
            // Register arithmetic, unknown opcodes stay a plain step
            ctrl_dec.alu_bs      = 1'b1;
            ctrl_dec.register_sa = instr[9:5];
            ctrl_dec.register_sb = instr[20:16];
            ctrl_dec.register_wa = instr[4:0];
            ctrl_dec.status_load = op == cpu_pkg::op_adds || op == cpu_pkg::op_subs ||
                                   op == cpu_pkg::op_ands;
            case (op)
                cpu_pkg::op_add, cpu_pkg::op_adds: ctrl_dec.alu_fs = cpu_pkg::alu_add;
                cpu_pkg::op_sub, cpu_pkg::op_subs: ctrl_dec.alu_fs = cpu_pkg::alu_sub;
                cpu_pkg::op_and, cpu_pkg::op_ands: ctrl_dec.alu_fs = cpu_pkg::alu_and;
                cpu_pkg::op_orr:                   ctrl_dec.alu_fs = cpu_pkg::alu_or;
                cpu_pkg::op_eor:                   ctrl_dec.alu_fs = cpu_pkg::alu_xor;
                default:                           ctrl_dec.alu_bs = 1'b0;
            endcase
            ctrl_dec.alu_enable = ctrl_dec.alu_bs;
            ctrl_dec.pc_enable  = !ctrl_dec.alu_bs;
            ctrl_dec.register_w = ctrl_dec.alu_bs;
        end
    end

    assign ctrl     = imm_class ? ctrl_imm : ctrl_dec;
    assign constant = imm_class ? const_imm : const_dec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= cpu_pkg::st_execute;
        end else begin
            state_q <= ctrl.next_state;
        end
    end

    // One bus driver per cycle across both decoders
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot({ctrl.alu_enable, ctrl.rf_b_enable, ctrl.ram_enable, ctrl.pc_enable}));

    // A load's second cycle reads RAM into the register file
    assert property (@(posedge clk) disable iff (!rst_n)
        (state_q == cpu_pkg::st_execute && ctrl.next_state == cpu_pkg::st_load_complete)
        |=> (ctrl.ram_enable && ctrl.register_w));

endmodule

// File: src/datapath.sv
/* Datapath with data RAM */
module datapath #(
    parameter int ram_depth = 256
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ctrl_word_t ctrl,
    input  cpu_pkg::word_t      constant,
    output cpu_pkg::status_t    status,
    output cpu_pkg::word_t      pc,
    output logic                wb_valid,
    output cpu_pkg::reg_addr_t  wb_addr,
    output cpu_pkg::word_t      wb_data
);

    localparam int ram_aw = $clog2(ram_depth);

    cpu_pkg::word_t   pc_q;
    cpu_pkg::word_t   pc_operand;
    cpu_pkg::status_t status_q;
    cpu_pkg::status_t alu_flags;
    cpu_pkg::word_t   bus;
    cpu_pkg::word_t   rda;
    cpu_pkg::word_t   rdb;
    cpu_pkg::word_t   alu_b;
    cpu_pkg::word_t   alu_y;
    cpu_pkg::word_t   ram_q;
    cpu_pkg::word_t   ram_addr_q;
    cpu_pkg::word_t   ram [ram_depth];

    register_file u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .ra    (ctrl.register_sa),
        .rb    (ctrl.register_sb),
        .wa    (ctrl.register_wa),
        .we    (ctrl.register_w),
        .wd    (bus),
        .rda   (rda),
        .rdb   (rdb)
    );

    // B select, 0 takes the constant
    assign alu_b = ctrl.alu_bs ? rdb : constant;

    alu u_alu (
        .a     (rda),
        .b     (alu_b),
        .fs    (ctrl.alu_fs),
        .y     (alu_y),
        .flags (alu_flags)
    );

    // Databus, one enable at a time
    always_comb begin
        unique case (1'b1)
            ctrl.alu_enable:  bus = alu_y;
            ctrl.rf_b_enable: bus = rdb;
            ctrl.ram_enable:  bus = ram_q;
            ctrl.pc_enable:   bus = pc_q;
            default:          bus = '0;
        endcase
    end

    // Word RAM, read address captured every cycle for the load's second cycle
    always_ff @(posedge clk) begin
        ram_addr_q <= alu_y;
        if (ctrl.ram_w) begin
            ram[alu_y[ram_aw+2:3]] <= bus;
        end
    end
    assign ram_q = ram[ram_addr_q[ram_aw+2:3]];

    // Program counter
    assign pc_operand = ctrl.pc_input_select ? constant : bus;
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else begin
            case (ctrl.pc_fs)
                cpu_pkg::pc_inc:  pc_q <= pc_q + 64'd4;
                cpu_pkg::pc_add:  pc_q <= pc_q + pc_operand;
                cpu_pkg::pc_load: pc_q <= pc_operand;
                default:          pc_q <= pc_q;
            endcase
        end
    end

    // Status register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= '0;
        end else if (ctrl.status_load) begin
            status_q <= alu_flags;
        end
    end

    // Stored flags, bz passed through live
    assign status = {status_q.v, status_q.c, status_q.n, status_q.z, alu_flags.bz};
    assign pc     = pc_q;

    // Write-back trace, quiet while reset is held
    assign wb_valid = rst_n && ctrl.register_w && ctrl.register_wa != cpu_pkg::reg_zero;
    assign wb_addr  = ctrl.register_wa;
    assign wb_data  = bus;

    // Load address latched in the execute cycle stays inside the RAM
    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.ram_enable |-> (ram_addr_q[63:3] < 61'(ram_depth)));

    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.ram_w |-> (alu_y[63:3] < 61'(ram_depth)));

endmodule

// File: src/cpu_top.sv
/* CPU top */
module cpu_top #(
    parameter int ram_depth = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::instr_t    instr,
    output cpu_pkg::word_t     instr_addr,
    output logic               wb_valid,
    output cpu_pkg::reg_addr_t wb_addr,
    output cpu_pkg::word_t     wb_data
);

    cpu_pkg::ctrl_word_t ctrl;
    cpu_pkg::word_t      constant;
    cpu_pkg::status_t    status;

    control_unit u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .status   (status),
        .ctrl     (ctrl),
        .constant (constant)
    );

    // PC doubles as the instruction address
    datapath #(
        .ram_depth (ram_depth)
    ) u_dp (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .constant (constant),
        .status   (status),
        .pc       (instr_addr),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

// File: bench/cpu_tb.sv
/* CPU core testbench */
module cpu_tb;

    localparam int reset_cycles = 16;
    localparam int prog_words   = 128;

    typedef enum logic [2:0] {k_imm, k_reg, k_ld, k_st, k_b, k_bcond, k_cbz, k_cbnz} kind_t;
    typedef enum logic [2:0] {f_add, f_sub, f_and, f_or, f_xor} fn_t;

    // One program entry as the reference model sees it
    typedef struct packed {
        kind_t              kind;
        fn_t                fn;
        logic               setf;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::reg_addr_t rn;
        cpu_pkg::reg_addr_t rm;
        logic [3:0]         cond;
        cpu_pkg::word_t     imm;
    } op_t;

    logic               clk;
    logic               rst_n;
    cpu_pkg::instr_t    instr;
    cpu_pkg::word_t     instr_addr;
    logic               wb_valid;
    cpu_pkg::reg_addr_t wb_addr;
    cpu_pkg::word_t     wb_data;

    cpu_pkg::instr_t prog [prog_words];
    op_t             ops [prog_words];
    string           test_names [5];
    int              test_start [5];
    int              n_ops = 0;
    int              end_idx = 0;
    int              cur_test = 0;
    int              errors = 0;
    int              test_errors = 0;
    int              failed_tests = 0;
    int              cycle = 0;
    int              timeout_limit = 0;

    // Reference state for the current cycle
    cpu_pkg::word_t     m_pc;
    logic               m_wait;
    logic               m_z;
    logic               m_n;
    logic               m_v;
    cpu_pkg::word_t     m_regs [32];
    cpu_pkg::word_t     m_ram [256];
    op_t                cur;
    cpu_pkg::word_t     m_a;
    cpu_pkg::word_t     m_b;
    cpu_pkg::word_t     m_res;
    cpu_pkg::word_t     nxt_pc;
    logic               exp_we;
    logic               exp_valid;
    cpu_pkg::reg_addr_t exp_wa;
    cpu_pkg::word_t     exp_wd;

    cpu_top #(
        .ram_depth (256)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .instr_addr (instr_addr),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    // Instruction memory answers in the same cycle
    assign instr = prog[instr_addr[8:2]];

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic cpu_pkg::instr_t encode(op_t r);
        logic [9:0] op;
        case (r.kind)
            k_imm: begin
                op = cpu_pkg::op_imm_arith;
                op[cpu_pkg::op_sub_bit]  = (r.fn == f_sub);
                op[cpu_pkg::op_setf_bit] = r.setf;
                return {op, r.imm[11:0], r.rn, r.rd};
            end
            k_reg: begin
                case (r.fn)
                    f_add:   op = r.setf ? cpu_pkg::op_adds : cpu_pkg::op_add;
                    f_sub:   op = r.setf ? cpu_pkg::op_subs : cpu_pkg::op_sub;
                    f_and:   op = cpu_pkg::op_and;
                    f_or:    op = cpu_pkg::op_orr;
                    default: op = cpu_pkg::op_eor;
                endcase
                return {op, 1'b0, r.rm, 6'd0, r.rn, r.rd};
            end
            k_ld:    return {cpu_pkg::op_ldur, 1'b0, r.imm[8:0], 2'b00, r.rn, r.rd};
            k_st:    return {cpu_pkg::op_stur, 1'b0, r.imm[8:0], 2'b00, r.rn, r.rd};
            k_b:     return {cpu_pkg::op_b, r.imm[27:2]};
            k_bcond: return {cpu_pkg::op_bcond, r.imm[20:2], 1'b0, r.cond};
            k_cbz:   return {cpu_pkg::op_cbz, r.imm[20:2], r.rd};
            default: return {cpu_pkg::op_cbnz, r.imm[20:2], r.rd};
        endcase
    endfunction

    // Append one instruction, encoded word and model entry side by side
    task automatic put(kind_t k, fn_t f, logic s, int rd, int rn, int rm, longint imm, int cond);
        op_t r;
        r = '{k, f, s, 5'(rd), 5'(rn), 5'(rm), 4'(cond), 64'(imm)};
        ops[n_ops]  = r;
        prog[n_ops] = encode(r);
        n_ops++;
    endtask

    task automatic start_test(int t, string name);
        test_start[t] = n_ops;
        test_names[t] = name;
    endtask

    task automatic build_program();
        int a;
        int b;
        start_test(0, "reset");
        // First instruction writes X30, so the trace is high in its cycle
        put(k_imm, f_add, 0, 30, 31, 0, $urandom_range(4095, 1), 0);
        start_test(1, "imm_arith");
        // Slot 6 targets XZR
        for (int i = 0; i < 12; i++) begin
            put(k_imm, ($urandom_range(1, 0) == 1) ? f_sub : f_add, 0, (i == 6) ? 31 : i % 10 + 1,
                $urandom_range(31, 0), 0, $urandom_range(4095, 0), 0);
        end
        start_test(2, "reg_arith");
        for (int i = 0; i < 15; i++) begin
            put(k_reg, fn_t'(i % 5), 0, $urandom_range(20, 1), $urandom_range(31, 0),
                $urandom_range(31, 0), 0, 0);
        end
        start_test(3, "branches");
        for (int j = 0; j < 6; j++) begin
            a = $urandom_range(20, 1);
            b = (j % 2 == 0) ? a : $urandom_range(20, 1);
            // Compare into XZR, then branch over the X21 increment
            if (j == 5) begin
                put(k_imm, f_sub, 1, 31, a, 0, $urandom_range(4095, 0), 0);
            end else begin
                put(k_reg, f_sub, 1, 31, a, b, 0, 0);
            end
            put(k_bcond, f_add, 0, 0, 0, 0, 8, (j % 3 == 0) ? cpu_pkg::cond_eq :
                (j % 3 == 1) ? cpu_pkg::cond_ne : cpu_pkg::cond_lt);
            put(k_imm, f_add, 0, 21, 21, 0, 1, 0);
        end
        put(k_cbz, f_add, 0, 31, 0, 0, 8, 0);
        put(k_imm, f_add, 0, 21, 21, 0, 1, 0);
        put(k_cbnz, f_add, 0, $urandom_range(20, 1), 0, 0, 8, 0);
        put(k_imm, f_add, 0, 21, 21, 0, 1, 0);
        put(k_b, f_add, 0, 0, 0, 0, 8, 0);
        put(k_imm, f_add, 0, 21, 21, 0, 1, 0);
        start_test(4, "load_store");
        // Two bases eight bytes apart reach the same word
        put(k_imm, f_add, 0, 22, 31, 0, 64, 0);
        put(k_imm, f_add, 0, 23, 31, 0, 72, 0);
        put(k_st, f_add, 0, 5, 22, 0, 16, 0);
        put(k_ld, f_add, 0, 24, 22, 0, 16, 0);
        put(k_ld, f_add, 0, 25, 23, 0, 8, 0);
        put(k_st, f_add, 0, 7, 23, 0, 32, 0);
        put(k_ld, f_add, 0, 26, 22, 0, 40, 0);
        put(k_reg, f_add, 0, 27, 24, 26, 0, 0);
        // Self loop at the end, every spare word branches back to it
        end_idx = n_ops;
        while (n_ops < prog_words) begin
            put(k_b, f_add, 0, 0, 0, 0, 4 * (end_idx - n_ops), 0);
        end
    endtask

    function automatic cpu_pkg::word_t alu_ref(fn_t f, cpu_pkg::word_t a, cpu_pkg::word_t b);
        case (f)
            f_sub:   return a - b;
            f_and:   return a & b;
            f_or:    return a | b;
            f_xor:   return a ^ b;
            default: return a + b;
        endcase
    endfunction

    function automatic logic cond_met(logic [3:0] c, logic z, logic n, logic v);
        case (c)
            cpu_pkg::cond_eq: return z;
            cpu_pkg::cond_ne: return !z;
            default:          return n != v;
        endcase
    endfunction

    // Expected outputs and next PC for the instruction at the model PC
    always_comb begin
        cur    = ops[m_pc[8:2]];
        m_a    = m_regs[cur.rn];
        m_b    = (cur.kind == k_reg) ? m_regs[cur.rm] : cur.imm;
        m_res  = alu_ref(cur.fn, m_a, m_b);
        exp_we = 1'b0;
        exp_wa = cur.rd;
        exp_wd = m_res;
        nxt_pc = m_pc + 64'd4;
        case (cur.kind)
            k_imm, k_reg: exp_we = 1'b1;
            k_ld: begin
                // First cycle holds the PC, second writes Rt
                exp_we = m_wait;
                exp_wd = m_ram[m_res[10:3]];
                if (!m_wait) begin
                    nxt_pc = m_pc;
                end
            end
            k_b:     nxt_pc = m_pc + cur.imm;
            k_bcond: nxt_pc = cond_met(cur.cond, m_z, m_n, m_v) ? m_pc + cur.imm : nxt_pc;
            k_cbz:   nxt_pc = (m_regs[cur.rd] == '0) ? m_pc + cur.imm : nxt_pc;
            k_cbnz:  nxt_pc = (m_regs[cur.rd] != '0) ? m_pc + cur.imm : nxt_pc;
            default: ;
        endcase
        // No trace while reset is held
        exp_valid = rst_n && exp_we && exp_wa != cpu_pkg::reg_zero;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_pc   <= '0;
            m_wait <= 1'b0;
            m_z    <= 1'b0;
            m_n    <= 1'b0;
            m_v    <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                m_regs[i] <= '0;
            end
        end else begin
            if (exp_valid) begin
                m_regs[exp_wa] <= exp_wd;
            end
            if (cur.kind == k_st) begin
                m_ram[m_res[10:3]] <= m_regs[cur.rd];
            end
            // Signed overflow only on add and subtract
            if ((cur.kind == k_imm || cur.kind == k_reg) && cur.setf) begin
                m_z <= m_res == '0;
                m_n <= m_res[63];
                m_v <= (cur.fn == f_sub) ? (m_a[63] != m_b[63]) && (m_res[63] != m_a[63]) :
                       (cur.fn == f_add) && (m_a[63] == m_b[63]) && (m_res[63] != m_a[63]);
            end
            m_wait <= (cur.kind == k_ld) && !m_wait;
            m_pc   <= nxt_pc;
        end
    end

    task automatic log_mismatch(string what, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        $display("Fail %s: %s expected %h, actual %h", test_names[cur_test], what, exp, act);
        errors++;
        test_errors++;
    endtask

    // PC parked at 0 and no trace while reset is held
    assert property (@(posedge clk) (!rst_n && cycle > 0) |-> instr_addr == '0)
        else log_mismatch("instr_addr in reset", '0, $sampled(instr_addr));
    assert property (@(posedge clk) (!rst_n && cycle > 0) |-> !wb_valid)
        else log_mismatch("wb_valid in reset", '0, 64'($sampled(wb_valid)));

    assert property (@(posedge clk) disable iff (!rst_n) instr_addr == m_pc)
        else log_mismatch("instr_addr", $sampled(m_pc), $sampled(instr_addr));
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid == exp_valid)
        else log_mismatch("wb_valid", 64'($sampled(exp_valid)), 64'($sampled(wb_valid)));
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> wb_addr == exp_wa)
        else log_mismatch("wb_addr", 64'($sampled(exp_wa)), 64'($sampled(wb_addr)));
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> wb_data == exp_wd)
        else log_mismatch("wb_data", $sampled(exp_wd), $sampled(wb_data));

    task automatic close_test();
        $display("Test %0d %s: %s, %0d errors", cur_test, test_names[cur_test],
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
        if (test_errors != 0) begin
            failed_tests++;
        end
        test_errors = 0;
        cur_test++;
    endtask

    // Between edges every check of the last edge has already run
    always @(negedge clk) begin
        if (rst_n && (m_pc == 64'(4 * end_idx) ||
                      (cur_test < 4 && m_pc >= 64'(4 * test_start[cur_test + 1])))) begin
            close_test();
        end
        if (rst_n && m_pc == 64'(4 * end_idx)) begin
            $display("Tests: 5, failed: %0d, errors: %0d", failed_tests, errors);
            if (errors == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end else if (cycle >= timeout_limit && timeout_limit > 0) begin
            $display("Timeout: program end not reached after %0d cycles", cycle);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        void'($urandom(88));
        clk   = 1'b0;
        rst_n = 1'b0;
        build_program();
        // Two cycles per instruction at most, with a wide margin
        timeout_limit = reset_cycles + 8 * end_idx;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: verilog.f
src/cpu_pkg.sv
src/imm_arith_decoder.sv
src/register_file.sv
src/alu.sv
src/control_unit.sv
src/datapath.sv
src/cpu_top.sv
bench/cpu_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing -Wall
TOP      = cpu_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
